//--- isi_settings.svh
`ifndef ISI_SETTINGS_SVH
`define ISI_SETTINGS_SVH

// pulse response length in UI
`define ISI_NUM_TAPS 4

// signed sample width
`define ISI_SIG_W 8

// signed coefficient width
`define ISI_COEF_W 8

// coefficient fraction bits, 64 is unity gain
`define ISI_COEF_FRAC 6

// spacing between adjacent PAM-4 levels, levels are -48 -16 16 48
`define ISI_SYM_SEP 32

`endif

//--- pam4_pkg.sv
`default_nettype none

`include "isi_settings.svh"

package pam4_pkg;

    // symbol codes in ascending level order
    typedef enum logic [1:0] {
        SYM_M3 = 2'd0,
        SYM_M1 = 2'd1,
        SYM_P1 = 2'd2,
        SYM_P3 = 2'd3
    } pam4_sym_e;

    // one stream sample, valid qualified
    typedef struct packed {
        logic                         valid;
        logic signed [`ISI_SIG_W-1:0] level;
    } sample_t;

    // single coefficient, named so array elements stay signed
    typedef logic signed [`ISI_COEF_W-1:0] coef_t;

    typedef coef_t [`ISI_NUM_TAPS-1:0] tap_coefs_t;

endpackage

`default_nettype wire

//--- apb_pkg.sv
`default_nettype none

package apb_pkg;

    // master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // register map, ctrl bit 0 is bypass
    typedef enum logic [7:0] {
        REG_TAP0 = 8'h00,
        REG_TAP1 = 8'h04,
        REG_TAP2 = 8'h08,
        REG_TAP3 = 8'h0C,
        REG_CTRL = 8'h10
    } reg_addr_e;

endpackage

`default_nettype wire

//--- channel_apb_regs.sv
`default_nettype none

`include "isi_settings.svh"

module channel_apb_regs (
    input  logic                 clk,
    input  logic                 rstn,
    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t    apb_rsp,
    output pam4_pkg::tap_coefs_t taps,
    output logic                 bypass
);

    localparam int IDX_W = $clog2(`ISI_NUM_TAPS);

    apb_pkg::reg_addr_e addr;
    logic [IDX_W-1:0]   tap_idx;
    logic               access;
    logic               addr_ok;
    logic               is_tap;
    logic [31:0]        rd_data;

    assign addr    = apb_pkg::reg_addr_e'(apb_req.paddr);
    assign tap_idx = apb_req.paddr[2 +: IDX_W];
    assign access  = apb_req.psel & apb_req.penable;

    // address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        is_tap  = 1'b0;
        rd_data = '0;
        case (addr)
            apb_pkg::REG_TAP0, apb_pkg::REG_TAP1,
            apb_pkg::REG_TAP2, apb_pkg::REG_TAP3: begin
                is_tap  = 1'b1;
                // taps read back sign-extended
                rd_data = {{(32-`ISI_COEF_W){taps[tap_idx][`ISI_COEF_W-1]}}, taps[tap_idx]};
            end
            apb_pkg::REG_CTRL: begin
                rd_data = {31'b0, bypass};
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // no wait states, every access completes at once
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access & ~addr_ok;
    assign apb_rsp.prdata  = access ? rd_data : 32'b0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // unity main cursor, no ISI
            for (int i = 0; i < `ISI_NUM_TAPS; i++) begin
                taps[i] <= (i == 0) ? pam4_pkg::coef_t'(1 << `ISI_COEF_FRAC) : '0;
            end
            bypass <= 1'b0;
        end else if (access && apb_req.pwrite && addr_ok) begin
            if (is_tap) begin
                taps[tap_idx] <= apb_req.pwdata[`ISI_COEF_W-1:0];
            end else begin
                bypass <= apb_req.pwdata[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- pam4_mapper.sv
`default_nettype none

`include "isi_settings.svh"

module pam4_mapper (
    input  logic                clk,
    input  logic                rstn,
    input  pam4_pkg::pam4_sym_e sym,
    input  logic                sym_valid,
    output pam4_pkg::sample_t   out
);

    int level_c;

    // level = (2*code - 3) * sep/2
    always_comb begin
        level_c = (2 * int'(sym) - 3) * (`ISI_SYM_SEP / 2);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= sym_valid;
        end
    end

    // level only follows real symbols
    always_ff @(posedge clk) begin
        if (sym_valid) begin
            out.level <= level_c[`ISI_SIG_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- isi_channel.sv
`default_nettype none

`include "isi_settings.svh"

module isi_channel (
    input  logic                 clk,
    input  logic                 rstn,
    input  pam4_pkg::sample_t    in,
    input  pam4_pkg::tap_coefs_t taps,
    input  logic                 bypass,
    output pam4_pkg::sample_t    out
);

    localparam int PROD_W = `ISI_SIG_W + `ISI_COEF_W;
    localparam int ACC_W  = PROD_W + $clog2(`ISI_NUM_TAPS);

    localparam logic signed [ACC_W-1:0] SAT_MAX = (1 <<< (`ISI_SIG_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(1 <<< (`ISI_SIG_W - 1));

    // past levels, hist[1] is the previous symbol
    logic signed [`ISI_SIG_W-1:0] hist [1:`ISI_NUM_TAPS-1];

    logic signed [ACC_W-1:0]      acc;
    logic signed [ACC_W-1:0]      scaled;
    logic signed [`ISI_SIG_W-1:0] sat;

    // weighted sum of current and past levels
    always_comb begin
        acc = in.level * taps[0];
        for (int i = 1; i < `ISI_NUM_TAPS; i++) begin
            acc = acc + hist[i] * taps[i];
        end
        scaled = acc >>> `ISI_COEF_FRAC;
        // clamp to the sample range
        if (scaled > SAT_MAX) begin
            sat = SAT_MAX[`ISI_SIG_W-1:0];
        end else if (scaled < SAT_MIN) begin
            sat = SAT_MIN[`ISI_SIG_W-1:0];
        end else begin
            sat = scaled[`ISI_SIG_W-1:0];
        end
    end

    // delay line advances on valid input only, also during bypass
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < `ISI_NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (in.valid) begin
            hist[1] <= in.level;
            for (int i = 2; i < `ISI_NUM_TAPS; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.level <= bypass ? in.level : sat;
        end
    end

endmodule

`default_nettype wire

//--- pam4_slicer.sv
`default_nettype none

`include "isi_settings.svh"

module pam4_slicer (
    input  logic                         clk,
    input  logic                         rstn,
    input  pam4_pkg::sample_t            in,
    output pam4_pkg::pam4_sym_e          rx_sym,
    output logic signed [`ISI_SIG_W-1:0] rx_level,
    output logic                         rx_valid
);

    localparam logic signed [`ISI_SIG_W-1:0] THR_HI = `ISI_SYM_SEP;
    localparam logic signed [`ISI_SIG_W-1:0] THR_LO = -`ISI_SYM_SEP;

    pam4_pkg::pam4_sym_e decision;

    // a sample on a threshold goes to the upper symbol
    always_comb begin
        if (in.level < THR_LO) begin
            decision = pam4_pkg::SYM_M3;
        end else if (in.level < 0) begin
            decision = pam4_pkg::SYM_M1;
        end else if (in.level < THR_HI) begin
            decision = pam4_pkg::SYM_P1;
        end else begin
            decision = pam4_pkg::SYM_P3;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            rx_sym   <= decision;
            rx_level <= in.level;
        end
    end

endmodule

`default_nettype wire

//--- isi_link_top.sv
`default_nettype none

`include "isi_settings.svh"

module isi_link_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  apb_pkg::apb_req_t            apb_req,
    output apb_pkg::apb_rsp_t            apb_rsp,
    input  pam4_pkg::pam4_sym_e          sym,
    input  logic                         sym_valid,
    output pam4_pkg::pam4_sym_e          rx_sym,
    output logic signed [`ISI_SIG_W-1:0] rx_level,
    output logic                         rx_valid
);

    pam4_pkg::tap_coefs_t taps;
    logic                 bypass;
    pam4_pkg::sample_t    tx_sample;
    pam4_pkg::sample_t    ch_sample;

    // configuration
    channel_apb_regs u_regs (
        .clk    (clk),
        .rstn   (rstn),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .taps   (taps),
        .bypass (bypass)
    );

    // symbols to levels
    pam4_mapper u_mapper (
        .clk      (clk),
        .rstn     (rstn),
        .sym      (sym),
        .sym_valid(sym_valid),
        .out      (tx_sample)
    );

    isi_channel u_channel (
        .clk   (clk),
        .rstn  (rstn),
        .in    (tx_sample),
        .taps  (taps),
        .bypass(bypass),
        .out   (ch_sample)
    );

    // receive decision
    pam4_slicer u_slicer (
        .clk     (clk),
        .rstn    (rstn),
        .in      (ch_sample),
        .rx_sym  (rx_sym),
        .rx_level(rx_level),
        .rx_valid(rx_valid)
    );

endmodule

`default_nettype wire

//--- isi_link_assert.sv
`default_nettype none

module isi_link_assert (
    input wire logic              clk,
    input wire logic              rstn,
    input wire apb_pkg::apb_req_t apb_req,
    input wire apb_pkg::apb_rsp_t apb_rsp,
    input wire logic              sym_valid,
    input wire logic              rx_valid
);

    // three register stages from symbol in to decision out
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        rx_valid == $past(sym_valid, 3))
        else $error("rx_valid does not follow sym_valid by 3 cycles");

    // pready only in an access phase that follows a setup phase
    a_pready: assert property (@(posedge clk)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable
                            && $past(apb_req.psel && !apb_req.penable)))
        else $error("pready high outside an APB access phase");

    a_reset_valid: assert property (@(posedge clk)
        !rstn |=> !rx_valid)
        else $error("rx_valid high after a reset cycle");

endmodule

bind isi_link_top isi_link_assert u_assert (
    .clk      (clk),
    .rstn     (rstn),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .sym_valid(sym_valid),
    .rx_valid (rx_valid)
);

`default_nettype wire

//--- isi_link_tb.sv
`default_nettype none

`include "isi_settings.svh"

module isi_link_tb;

    localparam int APB_TIMEOUT   = 16;
    localparam int DRAIN_TIMEOUT = 64;

    logic                         clk;
    logic                         rstn;
    apb_pkg::apb_req_t            apb_req;
    apb_pkg::apb_rsp_t            apb_rsp;
    pam4_pkg::pam4_sym_e          sym;
    logic                         sym_valid;
    pam4_pkg::pam4_sym_e          rx_sym;
    logic signed [`ISI_SIG_W-1:0] rx_level;
    logic                         rx_valid;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr   = 32'h9669da0a;

    // reference copy of the channel state
    int ref_taps [`ISI_NUM_TAPS];
    int ref_hist [`ISI_NUM_TAPS];
    bit ref_bypass;

    int         exp_level_q [$];
    logic [1:0] exp_sym_q [$];

    isi_link_top dut (
        .clk      (clk),
        .rstn     (rstn),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .sym      (sym),
        .sym_valid(sym_valid),
        .rx_sym   (rx_sym),
        .rx_level (rx_level),
        .rx_valid (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // levels one spacing apart and symmetric around zero
    function automatic int level_of(input logic [1:0] code);
        case (code)
            2'd0:    return -(`ISI_SYM_SEP + `ISI_SYM_SEP / 2);
            2'd1:    return -(`ISI_SYM_SEP / 2);
            2'd2:    return `ISI_SYM_SEP / 2;
            default: return `ISI_SYM_SEP + `ISI_SYM_SEP / 2;
        endcase
    endfunction

    function automatic int ref_level(input int cur);
        int acc;
        if (ref_bypass) begin
            return cur;
        end
        acc = cur * ref_taps[0];
        for (int k = 1; k < `ISI_NUM_TAPS; k++) begin
            acc += ref_hist[k] * ref_taps[k];
        end
        acc = acc >>> `ISI_COEF_FRAC;
        if (acc > 127) begin
            return 127;
        end else if (acc < -128) begin
            return -128;
        end
        return acc;
    endfunction

    // ties go to the upper symbol
    function automatic logic [1:0] ref_slice(input int lvl);
        if (lvl < -`ISI_SYM_SEP) begin
            return 2'd0;
        end else if (lvl < 0) begin
            return 2'd1;
        end else if (lvl < `ISI_SYM_SEP) begin
            return 2'd2;
        end
        return 2'd3;
    endfunction

    function automatic void model_symbol(input logic [1:0] code);
        int cur;
        int lvl;
        cur = level_of(code);
        lvl = ref_level(cur);
        exp_level_q.push_back(lvl);
        exp_sym_q.push_back(ref_slice(lvl));
        for (int k = `ISI_NUM_TAPS - 1; k > 1; k--) begin
            ref_hist[k] = ref_hist[k-1];
        end
        ref_hist[1] = cur;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int n;
        n = 0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready && n < APB_TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!apb_rsp.pready) begin
            $display("APB access to address 0x%h was never acknowledged", addr);
            errors++;
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic set_tap(input int i, input int val);
        logic err;
        apb_write(8'(4 * i), 32'(val), err);
        check("pslverr", 32'(err), 32'h0);
        ref_taps[i] = val;
    endtask

    task automatic set_taps(input int t0, input int t1, input int t2, input int t3);
        set_tap(0, t0);
        set_tap(1, t1);
        set_tap(2, t2);
        set_tap(3, t3);
    endtask

    task automatic set_bypass(input bit on);
        logic err;
        apb_write(8'h10, 32'(on), err);
        check("pslverr", 32'(err), 32'h0);
        ref_bypass = on;
    endtask

    // readback of the whole register map against the model
    task automatic check_regs();
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < `ISI_NUM_TAPS; i++) begin
            apb_read(8'(4 * i), rd, err);
            check("prdata", rd, 32'(ref_taps[i]));
            check("pslverr", 32'(err), 32'h0);
        end
        apb_read(8'h10, rd, err);
        check("prdata", rd, 32'(ref_bypass));
        check("pslverr", 32'(err), 32'h0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_level_q.size() != 0) begin
            if (n == DRAIN_TIMEOUT) begin
                $display("%0d expected outputs never came out", exp_level_q.size());
                errors++;
                exp_level_q.delete();
                exp_sym_q.delete();
                break;
            end
            n++;
            @(negedge clk);
        end
    endtask

    // fixed below zero means random symbols
    task automatic send_stream(input int count, input bit gaps, input int fixed);
        logic [1:0] code;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            if (gaps && rand_bits(2) == 32'd0) begin
                sym_valid = 1'b0;
                @(negedge clk);
            end
            code      = (fixed < 0) ? 2'(rand_bits(2)) : 2'(fixed);
            sym       = pam4_pkg::pam4_sym_e'(code);
            sym_valid = 1'b1;
            model_symbol(code);
        end
        @(negedge clk);
        sym_valid = 1'b0;
        wait_drain();
    endtask

    // compare every decision against the reference queue
    always @(posedge clk) begin
        int         exp_l;
        logic [1:0] exp_s;
        if (rstn && rx_valid) begin
            if (exp_level_q.size() == 0) begin
                $display("rx_valid high with no symbol outstanding");
                errors++;
            end else begin
                exp_l = exp_level_q.pop_front();
                exp_s = exp_sym_q.pop_front();
                check("rx_level", 32'(rx_level), 32'(exp_l));
                check("rx_sym", 32'(rx_sym), 32'(exp_s));
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [7:0]  b;
        apb_req    = '0;
        sym        = pam4_pkg::SYM_M3;
        sym_valid  = 1'b0;
        rstn       = 1'b0;
        ref_taps   = '{default: 0};
        ref_hist   = '{default: 0};
        ref_taps[0] = 1 << `ISI_COEF_FRAC;
        ref_bypass = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        // reset defaults on a unity channel
        check_regs();
        send_stream(16, 1'b0, -1);

        // register access with random coefficients
        for (int i = 0; i < `ISI_NUM_TAPS; i++) begin
            // odd taps negative, even taps positive
            b = {i[0], 7'(rand_bits(7))};
            set_tap(i, int'($signed(b)));
        end
        check_regs();
        apb_write(8'h14, rand_bits(32), err);
        check("pslverr", 32'(err), 32'h1);
        apb_read(8'h14, rd, err);
        check("pslverr", 32'(err), 32'h1);
        check("prdata", rd, 32'h0);
        check_regs();

        // ISI with gaps in the stream
        set_taps(64, 32, -16, 8);
        send_stream(60, 1'b1, -1);

        // saturation at both rails
        set_taps(127, 127, 127, 127);
        send_stream(8, 1'b0, 3);
        send_stream(8, 1'b0, 0);

        // bypass with the history still running underneath
        set_taps(40, 64, -48, 32);
        set_bypass(1'b1);
        send_stream(12, 1'b1, -1);
        set_bypass(1'b0);
        send_stream(12, 1'b1, -1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
pam4_pkg.sv
apb_pkg.sv
channel_apb_regs.sv
pam4_mapper.sv
isi_channel.sv
pam4_slicer.sv
isi_link_top.sv
isi_link_assert.sv
isi_link_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := isi_link_tb
FLIST     := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST)) isi_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
